// File: Makefile
# Verilator build and run of the timer subsystem testbench.

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  make test   build with Verilator and run the testbench"
	@echo "  make clean  remove the Verilator build directory"
	@echo "  make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module timer_subsystem_tb -Mdir obj_dir
	@out="$$(./obj_dir/Vtimer_subsystem_tb)"; echo "$$out"; \
		echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir

// File: dv/timer_subsystem_tb.sv
////////////////////////////////////////////////////////////
// Table-driven testbench for the timer subsystem.
// Build and run it with the test target of the Makefile.
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module timer_subsystem_tb;
    import timer_pkg::*;

    typedef enum logic [2:0] {
        OP_WRITE, OP_RWRITE, OP_READ, OP_MREAD, OP_WAIT, OP_IRQ, OP_FULL, OP_END
    } op_t;

    typedef struct packed {
        op_t       op;
        bus_addr_t address;
        word_t     data;
        strobe_t   strobe;
        word_t     expected;
    } step_t;

    // Write flag, address, write data and strobe.
    typedef logic [44:0] request_t;

    logic      bus         = 1'b0;
    logic      rst_n       = 1'b0;
    logic      cmd_push    = 1'b0;
    logic      cmd_write   = 1'b0;
    bus_addr_t cmd_address = '0;
    word_t     cmd_wdata   = '0;
    strobe_t   cmd_strobe  = '0;
    logic      cmd_full;
    logic      rsp_valid;
    word_t     rsp_rdata;
    logic      irq_a;
    logic      irq_b;

    step_t       steps[$];
    request_t    pending[$];
    word_t       expected_rsp[$];
    word_t       refill_model[2] = '{default: '0};
    logic [15:0] lfsr_state      = 16'd9;
    int          queue_occ       = 0;
    logic        seq_idle        = 1'b1;
    logic        full_seen       = 1'b0;
    int          cycle_count     = 0;
    int          timeout_limit   = 0;
    int          check_count     = 0;
    int          error_count     = 0;
    string       test_names[6]   = '{"reset values", "refill merge", "one-shot",
                                     "status clear", "periodic", "queue burst"};

    timer_subsystem timer_subsystem_inst (
        .bus         (bus),
        .rst_n       (rst_n),
        .cmd_push    (cmd_push),
        .cmd_write   (cmd_write),
        .cmd_address (cmd_address),
        .cmd_wdata   (cmd_wdata),
        .cmd_strobe  (cmd_strobe),
        .cmd_full    (cmd_full),
        .rsp_valid   (rsp_valid),
        .rsp_rdata   (rsp_rdata),
        .irq_a       (irq_a),
        .irq_b       (irq_b)
    );

    always #50 bus = ~bus;

    always @(posedge bus) begin
        cycle_count++;
        if (cycle_count > timeout_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
            $display("sim failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Request driver and response monitor
    ////////////////////////////////////////////////////////////

    // Occupancy follows the queue and sequencer rules, so a push
    // is only driven when the queue will have room.
    always @(posedge bus) begin : push_driver
        logic pop_now;
        if (!rst_n) begin
            queue_occ = 0;
            seq_idle  = 1'b1;
            cmd_push <= 1'b0;
        end else begin
            pop_now   = seq_idle && queue_occ != 0;
            queue_occ = queue_occ + (cmd_push ? 1 : 0) - (pop_now ? 1 : 0);
            seq_idle  = !pop_now;
            if (pending.size() != 0 && queue_occ < QUEUE_DEPTH) begin
                cmd_push <= 1'b1;
                {cmd_write, cmd_address, cmd_wdata, cmd_strobe} <= pending.pop_front();
            end else begin
                cmd_push <= 1'b0;
            end
        end
    end

    always @(negedge bus) begin : response_monitor
        word_t expected;
        if (rst_n) begin
            assert (cmd_full == (queue_occ == QUEUE_DEPTH)) else begin
                $display("FAIL %0t: cmd_full is %0b with %0d entries queued",
                         $time, cmd_full, queue_occ);
                error_count++;
            end
            if (cmd_full) begin
                full_seen = 1'b1;
            end
            if (rsp_valid) begin
                if (expected_rsp.size() == 0) begin
                    $display("A read response arrived with no read outstanding");
                    error_count++;
                end else begin
                    expected = expected_rsp.pop_front();
                    check_count++;
                    assert (rsp_rdata == expected) else begin
                        $display("FAIL %0t: read data %h, expected %h",
                                 $time, rsp_rdata, expected);
                        error_count++;
                    end
                end
            end
        end
    end

    // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsr_next(logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hb400) : (state >> 1);
    endfunction

    function automatic word_t random_bits(int count);
        word_t bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            bits       = {bits[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return bits;
    endfunction

    function automatic word_t merge_lanes(word_t current, word_t data, strobe_t strobe);
        word_t result;
        result = current;
        for (int lane = 0; lane < 4; lane++) begin
            if (strobe[lane]) begin
                result[8*lane +: 8] = data[8*lane +: 8];
            end
        end
        return result;
    endfunction

    function automatic bus_addr_t reg_addr(int timer, local_addr_t index);
        return bus_addr_t'(timer << TIMER_SELECT_BIT) | bus_addr_t'({index, 2'b00});
    endfunction

    function automatic void add_step(op_t op, bus_addr_t address, word_t data,
                                     strobe_t strobe, word_t expected);
        steps.push_back('{op, address, data, strobe, expected});
    endfunction

    // Refill writes also load count, so a stopped timer reads refill on both.
    task automatic queue_request(logic write, bus_addr_t address, word_t data,
                                 strobe_t strobe);
        local_addr_t index;
        index = address[3:2];
        if (write && index == REFILL_ADDR) begin
            refill_model[address[TIMER_SELECT_BIT]] =
                merge_lanes(refill_model[address[TIMER_SELECT_BIT]], data, strobe);
        end
        pending.push_back({write, address, data, strobe});
    endtask

    // The monitor matches responses in push order.
    task automatic read_and_check(bus_addr_t address, word_t expected);
        queue_request(1'b0, address, '0, '0);
        expected_rsp.push_back(expected);
    endtask

    task automatic wait_idle();
        while (pending.size() != 0 || cmd_push || queue_occ != 0 || !seq_idle) begin
            @(negedge bus);
        end
    endtask

    task automatic wait_responses();
        wait_idle();
        while (expected_rsp.size() != 0) begin
            @(negedge bus);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////////////////////////

    task automatic build_table();
        word_t ctrl_periodic;
        word_t ctrl_one_shot;
        word_t event_flag;
        ctrl_periodic = word_t'((1 << CTRL_COUNT_ENABLE_BIT) | (1 << CTRL_IRQ_ENABLE_BIT));
        ctrl_one_shot = ctrl_periodic | word_t'(1 << CTRL_ONE_SHOT_BIT);
        event_flag    = word_t'(1 << STATUS_EVENT_BIT);
        for (int t = 0; t < 2; t++) begin
            for (int r = 0; r < 4; r++) begin
                add_step(OP_READ, reg_addr(t, local_addr_t'(r)), '0, '0, '0);
            end
        end
        add_step(OP_IRQ, '0, '0, '0, 32'b00);
        add_step(OP_END, '0, 32'd0, '0, '0);
        for (int i = 0; i < 3; i++) begin
            add_step(OP_RWRITE, reg_addr(0, REFILL_ADDR), '0, '0, '0);
            add_step(OP_RWRITE, reg_addr(1, REFILL_ADDR), '0, '0, '0);
        end
        for (int t = 0; t < 2; t++) begin
            add_step(OP_MREAD, reg_addr(t, REFILL_ADDR), '0, '0, '0);
            add_step(OP_MREAD, reg_addr(t, COUNT_ADDR), '0, '0, '0);
        end
        add_step(OP_END, '0, 32'd1, '0, '0);
        // Reload of 5, so the event is due 6 cycles after the control write.
        add_step(OP_WRITE, reg_addr(0, REFILL_ADDR), 32'd5, 4'hf, '0);
        add_step(OP_WRITE, reg_addr(0, CONTROL_ADDR), ctrl_one_shot, 4'hf, '0);
        add_step(OP_WAIT, '0, 32'd8, '0, '0);
        add_step(OP_READ, reg_addr(0, STATUS_ADDR), '0, '0, event_flag);
        add_step(OP_READ, reg_addr(0, CONTROL_ADDR), '0, '0,
                 ctrl_one_shot & ~word_t'(1 << CTRL_COUNT_ENABLE_BIT));
        add_step(OP_MREAD, reg_addr(0, COUNT_ADDR), '0, '0, '0);
        add_step(OP_IRQ, '0, '0, '0, 32'b01);
        add_step(OP_END, '0, 32'd2, '0, '0);
        add_step(OP_WRITE, reg_addr(0, STATUS_ADDR), 32'd0, 4'hf, '0);
        add_step(OP_READ, reg_addr(0, STATUS_ADDR), '0, '0, event_flag);
        add_step(OP_IRQ, '0, '0, '0, 32'b01);
        add_step(OP_WRITE, reg_addr(0, STATUS_ADDR), event_flag, 4'hf, '0);
        add_step(OP_READ, reg_addr(0, STATUS_ADDR), '0, '0, '0);
        add_step(OP_IRQ, '0, '0, '0, 32'b00);
        add_step(OP_END, '0, 32'd3, '0, '0);
        add_step(OP_WRITE, reg_addr(0, CONTROL_ADDR), ctrl_periodic, 4'hf, '0);
        add_step(OP_WAIT, '0, 32'd7, '0, '0);
        add_step(OP_READ, reg_addr(0, STATUS_ADDR), '0, '0, event_flag);
        add_step(OP_READ, reg_addr(0, CONTROL_ADDR), '0, '0, ctrl_periodic);
        add_step(OP_WRITE, reg_addr(0, CONTROL_ADDR), 32'd0, 4'hf, '0);
        add_step(OP_WRITE, reg_addr(0, STATUS_ADDR), event_flag, 4'hf, '0);
        add_step(OP_READ, reg_addr(0, STATUS_ADDR), '0, '0, '0);
        add_step(OP_IRQ, '0, '0, '0, 32'b00);
        add_step(OP_END, '0, 32'd4, '0, '0);
        for (int i = 0; i < 8; i++) begin
            add_step(OP_RWRITE, reg_addr(i % 2, REFILL_ADDR), '0, '0, '0);
        end
        for (int t = 0; t < 2; t++) begin
            add_step(OP_MREAD, reg_addr(t, REFILL_ADDR), '0, '0, '0);
            add_step(OP_MREAD, reg_addr(t, COUNT_ADDR), '0, '0, '0);
        end
        add_step(OP_FULL, '0, '0, '0, '0);
        add_step(OP_END, '0, 32'd5, '0, '0);
    endtask

    initial begin
        step_t   s;
        int      test_start_errors;
        word_t   data;
        strobe_t strobe;
        build_table();
        test_start_errors = 0;
        // Reset, slack, then waits and 8 cycles per access.
        timeout_limit = 16 + 8;
        foreach (steps[i]) begin
            if (steps[i].op == OP_WAIT) begin
                timeout_limit += int'(steps[i].data);
            end else if (steps[i].op inside {OP_WRITE, OP_RWRITE, OP_READ, OP_MREAD}) begin
                timeout_limit += 8;
            end
        end
        repeat (16) @(posedge bus);
        rst_n <= 1'b1;
        @(negedge bus);
        foreach (steps[i]) begin
            s = steps[i];
            case (s.op)
                OP_WRITE: begin
                    queue_request(1'b1, s.address, s.data, s.strobe);
                end
                OP_RWRITE: begin
                    data   = random_bits(32);
                    strobe = strobe_t'(random_bits(4));
                    queue_request(1'b1, s.address, data, strobe);
                end
                OP_READ: begin
                    read_and_check(s.address, s.expected);
                end
                OP_MREAD: begin
                    read_and_check(s.address, refill_model[s.address[TIMER_SELECT_BIT]]);
                end
                OP_WAIT: begin
                    wait_idle();
                    repeat (s.data) @(negedge bus);
                end
                OP_IRQ: begin
                    wait_idle();
                    check_count++;
                    assert ({irq_b, irq_a} == s.expected[1:0]) else begin
                        $display("FAIL %0t: irq_b irq_a are %b, expected %b",
                                 $time, {irq_b, irq_a}, s.expected[1:0]);
                        error_count++;
                    end
                end
                OP_FULL: begin
                    wait_responses();
                    check_count++;
                    assert (full_seen) else begin
                        $display("The command queue never reported full during the burst");
                        error_count++;
                    end
                end
                OP_END: begin
                    wait_responses();
                    $display("Test %0d %s: %0d errors", s.data, test_names[s.data],
                             error_count - test_start_errors);
                    test_start_errors = error_count;
                    full_seen         = 1'b0;
                end
            endcase
        end
        $display("Checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
verilog/timer_pkg.sv
verilog/periph_bus_if.sv
verilog/cmd_queue.sv
verilog/bus_sequencer.sv
verilog/interval_timer.sv
verilog/timer_subsystem.sv
dv/timer_subsystem_tb.sv

// File: verilog/bus_sequencer.sv
////////////////////////////////////////////////////////////
// Drains the command queue, one peripheral access at a time.
// Read data comes back with a one-cycle rsp_valid pulse.
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module bus_sequencer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 head_write,
    input  timer_pkg::bus_addr_t head_address,
    input  timer_pkg::word_t     head_wdata,
    input  timer_pkg::strobe_t   head_strobe,
    input  logic                 empty,
    output logic                 pop,
    output logic                 rsp_valid,
    output timer_pkg::word_t     rsp_rdata,
    periph_bus_if.initiator      bus_a,
    periph_bus_if.initiator      bus_b
);
    import timer_pkg::*;

    typedef enum logic {IDLE, ACCESS} seq_state_t;

    seq_state_t state;
    logic       req_write;
    bus_addr_t  req_address;
    word_t      req_wdata;
    strobe_t    req_strobe;
    logic       target_b;
    logic       access_done;
    word_t      target_rdata;

    assign pop = (state == IDLE) && !empty;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else if (state == IDLE && pop) begin
            state <= ACCESS;
        end else if (state == ACCESS && access_done) begin
            state <= IDLE;
        end
    end

    // Latch the head entry as it is popped.
    always_ff @(posedge clk) begin
        if (pop) begin
            req_write   <= head_write;
            req_address <= head_address;
            req_wdata   <= head_wdata;
            req_strobe  <= head_strobe;
        end
    end

    assign target_b     = req_address[TIMER_SELECT_BIT];
    assign access_done  = target_b ? bus_b.ready : bus_a.ready;
    assign target_rdata = target_b ? bus_b.rdata : bus_a.rdata;

    assign bus_a.valid   = (state == ACCESS) && !target_b;
    assign bus_a.write   = req_write;
    assign bus_a.address = req_address;
    assign bus_a.wdata   = req_wdata;
    assign bus_a.strobe  = req_strobe;

    assign bus_b.valid   = (state == ACCESS) && target_b;
    assign bus_b.write   = req_write;
    assign bus_b.address = req_address;
    assign bus_b.wdata   = req_wdata;
    assign bus_b.strobe  = req_strobe;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= (state == ACCESS) && access_done && !req_write;
        end
    end

    always_ff @(posedge clk) begin
        if (state == ACCESS && access_done) begin
            rsp_rdata <= target_rdata;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) !(bus_a.valid && bus_b.valid))
        else $error("both peripheral buses active at once");

endmodule

`default_nettype wire

// File: verilog/cmd_queue.sv
////////////////////////////////////////////////////////////
// Command queue for pending bus requests from the host.
// Head entry is visible while empty is low.
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module cmd_queue (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                push,
    input  logic                push_write,
    input  timer_pkg::bus_addr_t push_address,
    input  timer_pkg::word_t    push_wdata,
    input  timer_pkg::strobe_t  push_strobe,
    input  logic                pop,
    output logic                head_write,
    output timer_pkg::bus_addr_t head_address,
    output timer_pkg::word_t    head_wdata,
    output timer_pkg::strobe_t  head_strobe,
    output logic                full,
    output logic                empty
);
    import timer_pkg::*;

    logic      write_mem   [QUEUE_DEPTH];
    bus_addr_t address_mem [QUEUE_DEPTH];
    word_t     wdata_mem   [QUEUE_DEPTH];
    strobe_t   strobe_mem  [QUEUE_DEPTH];

    logic [QUEUE_PTR_WIDTH-1:0]   wr_ptr;
    logic [QUEUE_PTR_WIDTH-1:0]   rd_ptr;
    logic [QUEUE_COUNT_WIDTH-1:0] count;
    logic                         do_push;
    logic                         do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign full    = count == QUEUE_COUNT_WIDTH'(QUEUE_DEPTH);
    assign empty   = count == '0;

    always_ff @(posedge clk) begin
        if (do_push) begin
            write_mem[wr_ptr]   <= push_write;
            address_mem[wr_ptr] <= push_address;
            wdata_mem[wr_ptr]   <= push_wdata;
            strobe_mem[wr_ptr]  <= push_strobe;
        end
    end

    // Pointers wrap naturally, depth is a power of two.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + QUEUE_COUNT_WIDTH'(do_push) - QUEUE_COUNT_WIDTH'(do_pop);
        end
    end

    assign head_write   = write_mem[rd_ptr];
    assign head_address = address_mem[rd_ptr];
    assign head_wdata   = wdata_mem[rd_ptr];
    assign head_strobe  = strobe_mem[rd_ptr];

    assert property (@(posedge clk) disable iff (!rst_n) !(push && full))
        else $error("push into a full command queue");
    assert property (@(posedge clk) disable iff (!rst_n) !(pop && empty))
        else $error("pop from an empty command queue");

endmodule

`default_nettype wire

// File: verilog/interval_timer.sv
////////////////////////////////////////////////////////////
// Reload-counter timer with an event flag and interrupt.
// Sits behind the target side of the peripheral bus.
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module interval_timer (
    periph_bus_if.target bus
);
    import timer_pkg::*;

    local_addr_t local_addr;
    word_t       control_reg;
    word_t       status_reg;
    word_t       refill_reg;
    word_t       count_reg;
    logic        count_enable;
    logic        one_shot;
    logic        irq_enable;
    logic        count_zero;
    logic        control_wr;
    logic        status_wr;
    logic        refill_wr;

    assign local_addr = local_addr_t'(bus.address[2 +: LOCAL_ADDR_WIDTH]);

    assign control_wr = bus.write_enabled() && local_addr == CONTROL_ADDR;
    assign status_wr  = bus.write_enabled() && local_addr == STATUS_ADDR;
    assign refill_wr  = bus.write_enabled() && local_addr == REFILL_ADDR;

    assign count_enable = control_reg[CTRL_COUNT_ENABLE_BIT];
    assign one_shot     = control_reg[CTRL_ONE_SHOT_BIT];
    assign irq_enable   = control_reg[CTRL_IRQ_ENABLE_BIT];
    assign count_zero   = count_reg == '0;

    always_ff @(posedge bus.clk) begin
        if (!bus.rst_n) begin
            control_reg <= '0;
        end else if (control_wr) begin
            control_reg <= bus.write_into(control_reg) & CONTROL_MASK;
        end else if (count_enable && one_shot && count_zero) begin
            control_reg[CTRL_COUNT_ENABLE_BIT] <= 1'b0;
        end
    end

    // Sticky event, cleared by writing one.
    always_ff @(posedge bus.clk) begin
        if (!bus.rst_n) begin
            status_reg <= '0;
        end else if (status_wr) begin
            status_reg <= bus.clear_into(status_reg);
        end else if (count_enable && count_zero) begin
            status_reg[STATUS_EVENT_BIT] <= 1'b1;
        end
    end

    always_ff @(posedge bus.clk) begin
        if (!bus.rst_n) begin
            refill_reg <= '0;
            count_reg  <= '0;
        end else if (refill_wr) begin
            refill_reg <= bus.write_into(refill_reg);
            count_reg  <= bus.write_into(count_reg);
        end else if (count_enable && !count_zero) begin
            count_reg <= count_reg - 1'b1;
        end else begin
            count_reg <= refill_reg;
        end
    end

    always_comb begin
        case (local_addr)
            CONTROL_ADDR: bus.rdata = control_reg;
            STATUS_ADDR:  bus.rdata = status_reg;
            REFILL_ADDR:  bus.rdata = refill_reg;
            COUNT_ADDR:   bus.rdata = count_reg;
            default:      bus.rdata = '0;
        endcase
    end

    assign bus.ready = bus.valid;
    assign bus.irq   = status_reg[STATUS_EVENT_BIT] && irq_enable;

    // Stopped counter only ever follows refill.
    assert property (@(posedge bus.clk) disable iff (!bus.rst_n)
        !count_enable && !refill_wr |=> count_reg == $past(refill_reg))
        else $error("count moved while count enable was clear");

endmodule

`default_nettype wire

// File: verilog/periph_bus_if.sv
////////////////////////////////////////////////////////////
// Internal peripheral bus between the sequencer and a timer.
// Targets tie ready to valid and use the merge functions.
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

interface periph_bus_if (
    input logic clk,
    input logic rst_n
);
    import timer_pkg::*;

    logic      valid;
    logic      write;
    bus_addr_t address;
    word_t     wdata;
    strobe_t   strobe;
    word_t     rdata;
    logic      ready;
    logic      irq;

    function automatic logic write_enabled();
        return valid && write;
    endfunction

    // Byte lanes under strobe take the write data.
    function automatic word_t write_into(word_t current);
        word_t merged;
        merged = current;
        for (int lane = 0; lane < STROBE_WIDTH; lane++) begin
            if (strobe[lane]) begin
                merged[8*lane +: 8] = wdata[8*lane +: 8];
            end
        end
        return merged;
    endfunction

    // Write one to clear, per enabled lane.
    function automatic word_t clear_into(word_t current);
        word_t merged;
        merged = current;
        for (int lane = 0; lane < STROBE_WIDTH; lane++) begin
            if (strobe[lane]) begin
                merged[8*lane +: 8] = current[8*lane +: 8] & ~wdata[8*lane +: 8];
            end
        end
        return merged;
    endfunction

    modport initiator (
        input  clk, rst_n, rdata, ready, irq,
        output valid, write, address, wdata, strobe
    );

    modport target (
        input  clk, rst_n, valid, write, address, wdata, strobe,
        output rdata, ready, irq,
        import write_enabled, write_into, clear_into
    );

endinterface

`default_nettype wire

// File: verilog/timer_pkg.sv
////////////////////////////////////////////////////////////
// Shared types and register map for the timer subsystem.
// Modules import it inside their bodies.
////////////////////////////////////////////////////////////

`default_nettype none

package timer_pkg;

    localparam int WORD_WIDTH       = 32;
    localparam int STROBE_WIDTH     = WORD_WIDTH / 8;
    localparam int BUS_ADDR_WIDTH   = 8;
    localparam int LOCAL_ADDR_WIDTH = 2;

    typedef logic [WORD_WIDTH-1:0]       word_t;
    typedef logic [BUS_ADDR_WIDTH-1:0]   bus_addr_t;
    typedef logic [LOCAL_ADDR_WIDTH-1:0] local_addr_t;
    typedef logic [STROBE_WIDTH-1:0]     strobe_t;

    // Register indices within one timer.
    localparam local_addr_t CONTROL_ADDR = 2'd0;
    localparam local_addr_t STATUS_ADDR  = 2'd1;
    localparam local_addr_t REFILL_ADDR  = 2'd2;
    localparam local_addr_t COUNT_ADDR   = 2'd3;

    // Control and status bit positions.
    localparam int CTRL_COUNT_ENABLE_BIT = 0;
    localparam int CTRL_ONE_SHOT_BIT     = 1;
    localparam int CTRL_IRQ_ENABLE_BIT   = 2;
    localparam int STATUS_EVENT_BIT      = 0;

    // Implemented control bits, the rest read as zero.
    localparam word_t CONTROL_MASK = word_t'((1 << CTRL_COUNT_ENABLE_BIT) |
                                             (1 << CTRL_ONE_SHOT_BIT) |
                                             (1 << CTRL_IRQ_ENABLE_BIT));

    localparam int QUEUE_DEPTH       = 4;
    localparam int QUEUE_PTR_WIDTH   = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_COUNT_WIDTH = QUEUE_PTR_WIDTH + 1;

    // Address bit that picks timer a or timer b.
    localparam int TIMER_SELECT_BIT = 4;

endpackage

`default_nettype wire

// File: verilog/timer_subsystem.sv
////////////////////////////////////////////////////////////
// Timer subsystem top: command queue, bus sequencer and
// two interval timers. Host pushes requests on cmd_push.
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module timer_subsystem (
    input  logic                 bus,
    input  logic                 rst_n,
    input  logic                 cmd_push,
    input  logic                 cmd_write,
    input  timer_pkg::bus_addr_t cmd_address,
    input  timer_pkg::word_t     cmd_wdata,
    input  timer_pkg::strobe_t   cmd_strobe,
    output logic                 cmd_full,
    output logic                 rsp_valid,
    output timer_pkg::word_t     rsp_rdata,
    output logic                 irq_a,
    output logic                 irq_b
);
    import timer_pkg::*;

    logic      head_write;
    bus_addr_t head_address;
    word_t     head_wdata;
    strobe_t   head_strobe;
    logic      queue_empty;
    logic      queue_pop;

    cmd_queue cmd_queue_inst (
        .clk          (bus),
        .rst_n        (rst_n),
        .push         (cmd_push),
        .push_write   (cmd_write),
        .push_address (cmd_address),
        .push_wdata   (cmd_wdata),
        .push_strobe  (cmd_strobe),
        .pop          (queue_pop),
        .head_write   (head_write),
        .head_address (head_address),
        .head_wdata   (head_wdata),
        .head_strobe  (head_strobe),
        .full         (cmd_full),
        .empty        (queue_empty)
    );

    periph_bus_if bus_a_if (.clk(bus), .rst_n(rst_n));
    periph_bus_if bus_b_if (.clk(bus), .rst_n(rst_n));

    bus_sequencer bus_sequencer_inst (
        .clk          (bus),
        .rst_n        (rst_n),
        .head_write   (head_write),
        .head_address (head_address),
        .head_wdata   (head_wdata),
        .head_strobe  (head_strobe),
        .empty        (queue_empty),
        .pop          (queue_pop),
        .rsp_valid    (rsp_valid),
        .rsp_rdata    (rsp_rdata),
        .bus_a        (bus_a_if.initiator),
        .bus_b        (bus_b_if.initiator)
    );

    interval_timer timer_a_inst (.bus(bus_a_if.target));
    interval_timer timer_b_inst (.bus(bus_b_if.target));

    assign irq_a = bus_a_if.irq;
    assign irq_b = bus_b_if.irq;

endmodule

`default_nettype wire
